//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned REG_IDX_WIDTH = 5;

  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_ADDI = 6'd5,
    OP_LDW  = 6'd6,
    OP_STW  = 6'd7,
    OP_BEQ  = 6'd8,
    OP_JMP  = 6'd9
  } opcode_t;

  // instruction word, opcode in the top bits.
  typedef struct packed {
    opcode_t                  opcode;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic [REG_IDX_WIDTH-1:0] ra;
    logic [REG_IDX_WIDTH-1:0] rb;
    logic [10:0]              imm; // signed offset or immediate.
  } instr_t;

  typedef struct packed {
    logic                     valid;
    opcode_t                  opcode;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic                     reg_wr_en;
    logic [DATA_WIDTH-1:0]    a;
    logic [DATA_WIDTH-1:0]    b;
    logic [DATA_WIDTH-1:0]    imm_ext;
    logic [ADDR_WIDTH-1:0]    pc;
  } alu_op_t;

  typedef struct packed {
    logic                     valid;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic                     reg_wr_en;
    logic                     is_load;
    logic                     is_store;
    logic [DATA_WIDTH-1:0]    result; // alu result or memory address.
    logic [DATA_WIDTH-1:0]    store_data;
  } mem_op_t;

  typedef struct packed {
    logic                     valid;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic                     reg_wr_en;
    logic [DATA_WIDTH-1:0]    data;
  } wb_t;

  typedef struct packed {
    logic                  rd;
    logic                  wr;
    logic                  is_instr;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    logic                  is_instr;
    logic [DATA_WIDTH-1:0] data;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
`default_nettype none

module fetch_stage #(
  parameter int unsigned           ADDR_WIDTH = cpu_pkg::ADDR_WIDTH,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  stall_i,
  input  logic                  redirect_i,
  input  logic [ADDR_WIDTH-1:0] redirect_pc_i,
  input  logic                  fetch_grant_i,
  input  cpu_pkg::mem_rsp_t     rsp_i,
  output logic                  rd_req_o,
  output logic [ADDR_WIDTH-1:0] req_addr_o,
  output cpu_pkg::instr_t       instr_o,
  output logic [ADDR_WIDTH-1:0] instr_pc_o,
  output logic                  instr_valid_o
);
  import cpu_pkg::*;

  logic [ADDR_WIDTH-1:0] pc_q;
  logic [ADDR_WIDTH-1:0] pend_pc_q; // address of the outstanding read.
  logic                  pending_q;
  logic                  discard_q;
  logic                  active_q;
  logic                  buf_valid_q;
  instr_t                buf_instr_q;
  logic [ADDR_WIDTH-1:0] buf_pc_q;
  logic                  instr_rsp;

  assign instr_rsp  = rsp_i.valid & rsp_i.is_instr;
  assign rd_req_o   = active_q & ~pending_q & ~stall_i & ~redirect_i;
  assign req_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q        <= RESET_PC;
      pending_q   <= 1'b0;
      discard_q   <= 1'b0;
      active_q    <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (rd_req_o && fetch_grant_i) begin
        pc_q      <= pc_q + ADDR_WIDTH'(4);
        pend_pc_q <= pc_q;
      end
      if (rd_req_o && fetch_grant_i) pending_q <= 1'b1;
      else if (instr_rsp) pending_q <= 1'b0;
      // a read still in flight at redirect comes back stale.
      if (redirect_i) discard_q <= pending_q & ~instr_rsp;
      else if (instr_rsp) discard_q <= 1'b0;
      if (redirect_i) begin
        buf_valid_q <= 1'b0;
      end else if (instr_rsp && !discard_q) begin
        buf_valid_q <= 1'b1;
        buf_instr_q <= instr_t'(rsp_i.data);
        buf_pc_q    <= pend_pc_q;
      end else if (!stall_i) begin
        buf_valid_q <= 1'b0; // taken by decode.
      end
    end
  end

  assign instr_o       = buf_instr_q;
  assign instr_pc_o    = buf_pc_q;
  assign instr_valid_o = buf_valid_q;

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`default_nettype none

module decode_stage #(
  parameter int unsigned DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              stall_i,
  input  logic                              flush_i,
  input  cpu_pkg::instr_t                   instr_i,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]    instr_pc_i,
  input  logic                              instr_valid_i,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] ra_idx_o,
  output logic [cpu_pkg::REG_IDX_WIDTH-1:0] rb_idx_o,
  input  logic [DATA_WIDTH-1:0]             ra_data_i,
  input  logic [DATA_WIDTH-1:0]             rb_data_i,
  output logic                              consume_o,
  output cpu_pkg::alu_op_t                  alu_op_o
);
  import cpu_pkg::*;

  localparam int unsigned IMM_WIDTH = $bits(instr_i.imm);

  alu_op_t alu_op_d;
  alu_op_t alu_op_q;
  logic    writes_reg;

  assign ra_idx_o  = instr_i.ra;
  assign rb_idx_o  = instr_i.rb;
  assign consume_o = ~stall_i; // buffer leaves fetch at this edge.

  always_comb begin
    case (instr_i.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LDW: writes_reg = 1'b1;
      default: writes_reg = 1'b0;
    endcase
  end

  always_comb begin
    alu_op_d.valid     = instr_valid_i & ~flush_i;
    alu_op_d.opcode    = instr_i.opcode;
    alu_op_d.rd        = instr_i.rd;
    alu_op_d.reg_wr_en = writes_reg;
    alu_op_d.a         = ra_data_i;
    alu_op_d.b         = rb_data_i;
    alu_op_d.imm_ext   = {{(DATA_WIDTH-IMM_WIDTH){instr_i.imm[IMM_WIDTH-1]}}, instr_i.imm};
    alu_op_d.pc        = instr_pc_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_op_q.valid <= 1'b0;
    end else if (!stall_i) begin
      alu_op_q <= alu_op_d;
    end
  end

  assign alu_op_o = alu_op_q;

endmodule

`default_nettype wire

//--- source/alu_stage.sv
`default_nettype none

module alu_stage #(
  parameter int unsigned DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           stall_i,
  input  cpu_pkg::alu_op_t               alu_op_i,
  output logic                           redirect_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] redirect_pc_o,
  output cpu_pkg::mem_op_t               mem_op_o
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0] a;
  logic [DATA_WIDTH-1:0] b;
  logic [DATA_WIDTH-1:0] sum_imm;
  logic [DATA_WIDTH-1:0] result;
  logic [ADDR_WIDTH-1:0] imm_addr;
  logic [ADDR_WIDTH-1:0] br_target;
  logic                  taken;
  mem_op_t               mem_op_d;
  mem_op_t               mem_op_q;

  assign a        = alu_op_i.a;
  assign b        = alu_op_i.b;
  assign sum_imm  = a + alu_op_i.imm_ext; // addi, load/store address, jump target.
  assign imm_addr = ADDR_WIDTH'(alu_op_i.imm_ext);

  always_comb begin
    case (alu_op_i.opcode)
      OP_ADD:                  result = a + b;
      OP_SUB:                  result = a - b;
      OP_AND:                  result = a & b;
      OP_OR:                   result = a | b;
      OP_ADDI, OP_LDW, OP_STW: result = sum_imm;
      default:                 result = '0;
    endcase
  end

  assign br_target = alu_op_i.pc + ADDR_WIDTH'(4) + {imm_addr[ADDR_WIDTH-3:0], 2'b00};
  assign taken     = alu_op_i.valid &
                     ((alu_op_i.opcode == OP_BEQ && a == b) || alu_op_i.opcode == OP_JMP);

  // a held branch redirects once, when it leaves the stage.
  assign redirect_o    = taken & ~stall_i;
  assign redirect_pc_o = (alu_op_i.opcode == OP_JMP) ? ADDR_WIDTH'(sum_imm) : br_target;

  always_comb begin
    mem_op_d.valid      = alu_op_i.valid;
    mem_op_d.rd         = alu_op_i.rd;
    mem_op_d.reg_wr_en  = alu_op_i.reg_wr_en;
    mem_op_d.is_load    = alu_op_i.opcode == OP_LDW;
    mem_op_d.is_store   = alu_op_i.opcode == OP_STW;
    mem_op_d.result     = result;
    mem_op_d.store_data = b;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_op_q.valid <= 1'b0;
    end else if (!stall_i) begin
      mem_op_q <= mem_op_d;
    end
  end

  assign mem_op_o = mem_op_q;

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`default_nettype none

module mem_stage #(
  parameter int unsigned DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  cpu_pkg::mem_op_t               mem_op_i,
  input  cpu_pkg::mem_rsp_t              rsp_i,
  output logic                           rd_req_o,
  output logic                           wr_req_o,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] req_addr_o,
  output logic [DATA_WIDTH-1:0]          wdata_o,
  output logic                           stall_o,
  output cpu_pkg::wb_t                   wb_o
);
  import cpu_pkg::*;

  logic                     waiting_q;
  logic [REG_IDX_WIDTH-1:0] pend_rd_q;
  logic                     pend_wr_en_q;
  logic                     accept;
  logic                     is_mem;
  logic                     data_rsp;
  wb_t                      wb_d;
  wb_t                      wb_q;

  // while waiting, the op on mem_op_i is the next one, held by stall.
  assign accept   = mem_op_i.valid & ~waiting_q;
  assign is_mem   = mem_op_i.is_load | mem_op_i.is_store;
  assign data_rsp = rsp_i.valid & ~rsp_i.is_instr;

  assign rd_req_o   = accept & mem_op_i.is_load;
  assign wr_req_o   = accept & mem_op_i.is_store;
  assign req_addr_o = ADDR_WIDTH'(mem_op_i.result);
  assign wdata_o    = mem_op_i.store_data;
  assign stall_o    = waiting_q;

  always_comb begin
    wb_d.valid     = 1'b0;
    wb_d.rd        = mem_op_i.rd;
    wb_d.reg_wr_en = mem_op_i.reg_wr_en;
    wb_d.data      = waiting_q ? rsp_i.data : mem_op_i.result; // load data or alu result.
    if (waiting_q) begin
      wb_d.valid     = data_rsp;
      wb_d.rd        = pend_rd_q;
      wb_d.reg_wr_en = pend_wr_en_q;
    end else if (accept && !is_mem) begin
      wb_d.valid = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      waiting_q  <= 1'b0;
      wb_q.valid <= 1'b0;
    end else begin
      if (waiting_q && data_rsp) begin
        waiting_q <= 1'b0;
      end else if (accept && is_mem) begin
        waiting_q    <= 1'b1;
        pend_rd_q    <= mem_op_i.rd;
        pend_wr_en_q <= mem_op_i.reg_wr_en;
      end
      wb_q <= wb_d;
    end
  end

  assign wb_o = wb_q;

endmodule

`default_nettype wire

//--- source/rbank.sv
`default_nettype none

module rbank #(
  parameter int unsigned DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  cpu_pkg::wb_t                      wb_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] ra_idx_i,
  input  logic [cpu_pkg::REG_IDX_WIDTH-1:0] rb_idx_i,
  output logic [DATA_WIDTH-1:0]             ra_data_o,
  output logic [DATA_WIDTH-1:0]             rb_data_o
);
  import cpu_pkg::*;

  localparam int unsigned NUM_REGS = 1 << REG_IDX_WIDTH;

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];
  logic                  wr_en;

  assign wr_en = wb_i.valid & wb_i.reg_wr_en & (wb_i.rd != '0); // r0 stays zero.

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) regs_q[i] <= '0;
    end else if (wr_en) begin
      regs_q[wb_i.rd] <= wb_i.data;
    end
  end

  // write-through.
  assign ra_data_o = (wr_en && wb_i.rd == ra_idx_i) ? wb_i.data : regs_q[ra_idx_i];
  assign rb_data_o = (wr_en && wb_i.rd == rb_idx_i) ? wb_i.data : regs_q[rb_idx_i];

endmodule

`default_nettype wire

//--- source/cpu.sv
`default_nettype none

module cpu #(
  parameter int unsigned           DATA_WIDTH = cpu_pkg::DATA_WIDTH,
  parameter int unsigned           ADDR_WIDTH = cpu_pkg::ADDR_WIDTH,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::mem_rsp_t mem_rsp_i,
  output cpu_pkg::mem_req_t mem_req_o
);
  import cpu_pkg::*;

  logic                     fetch_rd_req;
  logic [ADDR_WIDTH-1:0]    fetch_addr;
  logic                     fetch_grant;
  instr_t                   fetch_instr;
  logic [ADDR_WIDTH-1:0]    fetch_pc;
  logic                     fetch_valid;
  logic [REG_IDX_WIDTH-1:0] ra_idx;
  logic [REG_IDX_WIDTH-1:0] rb_idx;
  logic [DATA_WIDTH-1:0]    ra_data;
  logic [DATA_WIDTH-1:0]    rb_data;
  logic                     dec_consume;
  alu_op_t                  alu_op;
  logic                     redirect;
  logic [ADDR_WIDTH-1:0]    redirect_pc;
  mem_op_t                  mem_op;
  logic                     mem_rd_req;
  logic                     mem_wr_req;
  logic [ADDR_WIDTH-1:0]    mem_addr;
  logic [DATA_WIDTH-1:0]    mem_wdata;
  logic                     stall;
  wb_t                      wb;

  fetch_stage #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RESET_PC   (RESET_PC)
  ) fetch0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (~dec_consume), // decode holds its input while the pipe is stalled.
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .fetch_grant_i (fetch_grant),
    .rsp_i         (mem_rsp_i),
    .rd_req_o      (fetch_rd_req),
    .req_addr_o    (fetch_addr),
    .instr_o       (fetch_instr),
    .instr_pc_o    (fetch_pc),
    .instr_valid_o (fetch_valid)
  );

  decode_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) decode0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall),
    .flush_i       (redirect),
    .instr_i       (fetch_instr),
    .instr_pc_i    (fetch_pc),
    .instr_valid_i (fetch_valid),
    .ra_idx_o      (ra_idx),
    .rb_idx_o      (rb_idx),
    .ra_data_i     (ra_data),
    .rb_data_i     (rb_data),
    .consume_o     (dec_consume),
    .alu_op_o      (alu_op)
  );

  alu_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) alu0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall),
    .alu_op_i      (alu_op),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .mem_op_o      (mem_op)
  );

  mem_stage #(
    .DATA_WIDTH (DATA_WIDTH)
  ) mem0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .mem_op_i   (mem_op),
    .rsp_i      (mem_rsp_i),
    .rd_req_o   (mem_rd_req),
    .wr_req_o   (mem_wr_req),
    .req_addr_o (mem_addr),
    .wdata_o    (mem_wdata),
    .stall_o    (stall),
    .wb_o       (wb)
  );

  rbank #(
    .DATA_WIDTH (DATA_WIDTH)
  ) rbank0 (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_i      (wb),
    .ra_idx_i  (ra_idx),
    .rb_idx_i  (rb_idx),
    .ra_data_o (ra_data),
    .rb_data_o (rb_data)
  );

  // memory stage has priority on the shared port.
  assign fetch_grant = ~(mem_rd_req | mem_wr_req);

  always_comb begin
    mem_req_o.rd       = mem_rd_req | (fetch_rd_req & fetch_grant);
    mem_req_o.wr       = mem_wr_req;
    mem_req_o.is_instr = fetch_rd_req & fetch_grant;
    mem_req_o.addr     = fetch_grant ? fetch_addr : mem_addr;
    mem_req_o.wdata    = mem_wdata;
  end

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`default_nettype none

module clk_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // active low reset, released just after a rising edge.
  initial begin
    rst_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/cpu_sva.sv
`default_nettype none

module cpu_sva (
  input logic              clk_i,
  input logic              rst_i,
  input cpu_pkg::mem_req_t mem_req_o
);
  import cpu_pkg::*;

  // skip the first edge, the pipeline registers are not reset before it.
  no_req_in_reset: assert property (@(posedge clk_i)
    (!rst_i && $past(!rst_i)) |-> !(mem_req_o.rd || mem_req_o.wr))
    else $error("memory request issued during reset");

  rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(mem_req_o.rd && mem_req_o.wr))
    else $error("read and write requested in the same cycle");

  wr_not_instr: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o.wr |-> !mem_req_o.is_instr)
    else $error("write request tagged as instruction fetch");

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_i)
    (mem_req_o.rd || mem_req_o.wr) |-> (mem_req_o.addr[1:0] == 2'b00))
    else $error("request address not word aligned");

endmodule

bind cpu cpu_sva sva0 (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .mem_req_o (mem_req_o)
);

`default_nettype wire

//--- tests/cpu_tb.sv
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam logic [31:0] DATA_BASE   = 32'h280; // operand pairs.
  localparam logic [31:0] SLOT_BASE   = 32'h380; // result slots.
  localparam logic [31:0] MARKER      = 32'h5a;
  localparam int          N_ENTRIES   = 9;
  localparam int          TAIL_CYCLES = 100;

  typedef struct packed {
    opcode_t     op;
    logic [31:0] a;
    logic [31:0] b;
    logic        branch;
  } entry_t;

  logic        clk;
  logic        rst;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp = '0;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] rsp_data_q [$];
  logic        rsp_instr_q [$];
  int          rsp_due_q [$];
  entry_t      table_q [N_ENTRIES];
  integer      seed = 29560;
  int          cycle = 0;
  int          last_due = 0;
  int          errors = 0;
  int          limit = 0;
  bit          first_seen = 1'b0;

  clk_gen clk_gen0 (
    .clk_o (clk),
    .rst_o (rst)
  );

  cpu #(
    .DATA_WIDTH (32),
    .ADDR_WIDTH (32),
    .RESET_PC   (32'h0)
  ) dut0 (
    .clk_i     (clk),
    .rst_i     (rst),
    .mem_rsp_i (mem_rsp),
    .mem_req_o (mem_req)
  );

  function automatic logic [31:0] encode(opcode_t op, int rd, int ra, int rb, int imm);
    return {op, 5'(rd), 5'(ra), 5'(rb), 11'(imm)};
  endfunction

  function automatic logic [31:0] expected_result(opcode_t op, logic [31:0] a, logic [31:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      default: return 32'h0;
    endcase
  endfunction

  // unwritten words read back as a pattern of their address.
  function automatic logic [31:0] read_word(logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return ~addr ^ 32'h1357_9bdf;
  endfunction

  task automatic emit(logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic nops(int n);
    repeat (n) emit(encode(OP_NOP, 0, 0, 0, 0));
  endtask

  task automatic expect_write(logic [31:0] addr, logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic build_program();
    entry_t      e;
    logic [31:0] slot;
    logic [31:0] da;
    emit(encode(OP_ADDI, 3, 0, 0, MARKER));
    for (int i = 0; i < N_ENTRIES; i++) begin
      e    = table_q[i];
      slot = SLOT_BASE + 32'(4 * i);
      da   = DATA_BASE + 32'(8 * i);
      mem[da]      = e.a;
      mem[da + 4]  = e.b;
      emit(encode(OP_LDW, 1, 0, 0, da));
      emit(encode(OP_LDW, 2, 0, 0, da + 4));
      nops(3); // load results must land before the read.
      if (e.branch) begin
        emit(encode(OP_BEQ, 0, 1, 2, 1)); // skips the marker store when equal.
        emit(encode(OP_STW, 0, 0, 3, slot));
        if (e.a != e.b) expect_write(slot, MARKER);
      end else begin
        emit(encode(e.op, 4, 1, 2, 0));
        nops(3);
        emit(encode(OP_STW, 0, 0, 4, slot));
        expect_write(slot, expected_result(e.op, e.a, e.b));
      end
    end
    // r0 ignores writes.
    slot = SLOT_BASE + 32'(4 * N_ENTRIES);
    emit(encode(OP_ADDI, 0, 0, 0, 77));
    nops(3);
    emit(encode(OP_STW, 0, 0, 0, slot));
    expect_write(slot, 32'h0);
    emit(encode(OP_JMP, 0, 0, 0, prog.size() * 4));
    emit(encode(OP_STW, 0, 0, 3, slot + 4)); // reached only if the jump falls through.
    foreach (prog[i]) mem[32'(i * 4)] = prog[i];
  endtask

  task automatic check_write(logic [31:0] addr, logic [31:0] data);
    logic [31:0] ea;
    logic [31:0] ed;
    if (exp_addr.size() == 0) begin
      errors++;
      $display("unexpected extra write of %h to address %h at time %0t", data, addr, $time);
    end else begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      if (addr != ea || data != ed) begin
        errors++;
        $display("ERROR %0t: write %h to %h, expected %h to %h", $time, data, addr, ed, ea);
      end
    end
  endtask

  // responses go out in order, 1 to 4 cycles after the request.
  always @(posedge clk) begin
    cycle++;
    #1;
    if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle) begin
      mem_rsp.valid    = 1'b1;
      mem_rsp.is_instr = rsp_instr_q.pop_front();
      mem_rsp.data     = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end else begin
      mem_rsp = '0;
    end
  end

  // requests are stable by the falling edge.
  always @(negedge clk) begin
    int          due;
    logic [31:0] data;
    if (rst && (mem_req.rd || mem_req.wr)) begin
      if (!first_seen) begin
        first_seen = 1'b1;
        if (!(mem_req.rd && mem_req.is_instr && mem_req.addr == 32'h0)) begin
          errors++;
          $display("ERROR %0t: first request is not an instruction read at 0 (addr %h)",
                   $time, mem_req.addr);
        end
      end
      due = cycle + 1 + int'($unsigned($random(seed)) % 4);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      if (mem_req.wr) begin
        check_write(mem_req.addr, mem_req.wdata);
        mem[mem_req.addr] = mem_req.wdata;
        data = 32'h0;
      end else begin
        data = read_word(mem_req.addr);
      end
      rsp_data_q.push_back(data);
      rsp_instr_q.push_back(mem_req.is_instr);
      rsp_due_q.push_back(due);
    end
  end

  initial begin
    table_q[0] = '{OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b0};
    table_q[1] = '{OP_SUB, 32'h0000_0005, 32'h0000_0007, 1'b0};
    table_q[2] = '{OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, 1'b0};
    table_q[3] = '{OP_OR,  32'h1234_0000, 32'h0000_5678, 1'b0};
    table_q[4] = '{OP_ADD, 32'hffff_ffff, 32'hffff_ffff, 1'b0};
    table_q[5] = '{OP_SUB, 32'h0000_0000, 32'h8000_0000, 1'b0};
    table_q[6] = '{OP_BEQ, 32'h0000_002a, 32'h0000_002a, 1'b1};
    table_q[7] = '{OP_BEQ, 32'h0000_0001, 32'h0000_0002, 1'b1};
    table_q[8] = '{OP_BEQ, 32'hdead_beef, 32'hdead_beef, 1'b1};
    build_program();
    limit = prog.size() * 16 + 200;
    wait (rst);
    while (exp_addr.size() != 0 && cycle < limit) @(posedge clk);
    if (exp_addr.size() != 0) begin
      errors++;
      $display("timeout after %0d cycles with %0d expected writes still missing",
               cycle, exp_addr.size());
    end else begin
      repeat (TAIL_CYCLES) @(posedge clk); // any write here is an extra one.
    end
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/alu_stage.sv
source/mem_stage.sv
source/rbank.sv
source/cpu.sv
tests/clk_gen.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

//--- Makefile
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
